// File: design/rv_pipe_config.svh
//--------------------------------------------------------------------------
// Core sizing and reset vector. RV32I only, so XLEN must stay 32
// Register index width is derived from the register count
//--------------------------------------------------------------------------

`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

// First fetch address after reset
`define RV_RESET_VECTOR 32'h0008_0000

`endif

// File: design/rv_pipe_pkg.sv
//--------------------------------------------------------------------------
// Shared types of the pipeline. Opcodes outside opcode_e decode as no-ops
//--------------------------------------------------------------------------

`include "rv_pipe_config.svh"

package rv_pipe_pkg;

  typedef logic [`RV_XLEN-1:0]          word_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

  // Major opcodes still handled by the decoder
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_b                          // LUI immediate straight through
  } alu_op_e;

  typedef enum logic [2:0] {
    mem_none, mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu, mem_sw
  } mem_op_e;

  // D -> X
  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    mem_op_e  mem_op;
    reg_idx_t rd;
    logic     we;                       // Already excludes x0
    word_t    op_a;
    word_t    op_b;
    word_t    st_data;
  } dx_t;

  // X -> M
  typedef struct packed {
    logic     valid;
    mem_op_e  mem_op;
    reg_idx_t rd;
    logic     we;
    word_t    result;
  } xm_t;

  // W stage record, also the exported writeback port
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

// File: design/rv_fetch.sv
//--------------------------------------------------------------------------
// Fetch. Instruction memory returns data one cycle after the address
// No branches, so the PC only steps by 4 or replays the D-stage pc
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_pipe_config.svh"

module rv_fetch import rv_pipe_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  input  word_t imem_data,
  output word_t imem_addr,
  output word_t pc_d,
  output word_t inst_d,
  output logic  valid_d
);

  word_t pc_f;                            // Next sequential fetch

  // Replay the stalled instruction by asking for its pc again
  assign imem_addr = stall ? pc_d : pc_f;
  assign inst_d    = imem_data;           // Data lands during D

  always_ff @(posedge clk) begin
    pc_d <= imem_addr;                    // Pc of the word now in flight
    if (reset) begin
      pc_f    <= `RV_RESET_VECTOR;
      valid_d <= 1'b0;                    // Nothing requested yet
    end else begin
      pc_f    <= imem_addr + 32'd4;
      valid_d <= 1'b1;
    end
  end

endmodule

// File: design/rv_decode.sv
//--------------------------------------------------------------------------
// Decode and interlock. No bypass paths: D waits until the producer is in W
// Unsupported opcodes and funct encodings leave as bubbles
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rv_decode import rv_pipe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    pc_d,
  input  word_t    inst_d,
  input  logic     valid_d,
  input  xm_t      xm,
  input  word_t    rf_rdata_a,
  input  word_t    rf_rdata_b,
  output logic     stall,
  output reg_idx_t rf_raddr_a,
  output reg_idx_t rf_raddr_b,
  output dx_t      dx
);

  opcode_e  opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t rd;
  word_t    imm_i, imm_s, imm_u, shamt;
  alu_op_e  alu_op;
  mem_op_e  mem_op;
  word_t    op_b;
  logic     writes, use_a, use_b, known;
  logic     hit_x, hit_m;

  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  //------------------------------------------------------------------------
  // Fields and immediates
  //------------------------------------------------------------------------
  assign opcode     = opcode_e'(inst_d[6:0]);
  assign funct3     = inst_d[14:12];
  assign funct7     = inst_d[31:25];
  assign rd         = inst_d[11:7];
  assign rf_raddr_a = inst_d[19:15];
  assign rf_raddr_b = inst_d[24:20];
  assign imm_i = {{20{inst_d[31]}}, inst_d[31:20]};
  assign imm_s = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
  assign imm_u = {inst_d[31:12], 12'b0};
  assign shamt = word_t'(inst_d[24:20]);   // Zero-extended shift amount

  always_comb begin
    alu_op = alu_add;                      // Also the address adder
    mem_op = mem_none;
    op_b   = rf_rdata_b;
    writes = 1'b0;
    use_a  = 1'b0;
    use_b  = 1'b0;
    known  = 1'b1;
    case (opcode)
      opc_op: begin
        use_a  = 1'b1;
        use_b  = 1'b1;
        writes = 1'b1;
        alu_op = alu_from_funct(funct3, funct7[5]);
        // Only base and alternate encodings, M extension etc. dropped
        known  = (funct7 == 7'h00) ||
                 (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      opc_op_imm: begin
        use_a  = 1'b1;
        writes = 1'b1;
        alu_op = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
        op_b   = (funct3 == 3'b001 || funct3 == 3'b101) ? shamt : imm_i;
      end
      opc_lui: begin
        writes = 1'b1;
        alu_op = alu_pass_b;
        op_b   = imm_u;
      end
      opc_load: begin
        use_a  = 1'b1;
        writes = 1'b1;
        op_b   = imm_i;
        case (funct3)
          3'b000:  mem_op = mem_lb;
          3'b001:  mem_op = mem_lh;
          3'b010:  mem_op = mem_lw;
          3'b100:  mem_op = mem_lbu;
          3'b101:  mem_op = mem_lhu;
          default: known  = 1'b0;
        endcase
      end
      opc_store: begin
        use_a  = 1'b1;
        use_b  = 1'b1;                     // Store data comes from rs2
        op_b   = imm_s;
        mem_op = mem_sw;
        known  = (funct3 == 3'b010);       // SW only
      end
      default: known = 1'b0;
    endcase
  end

  //------------------------------------------------------------------------
  // Interlock against X and M, W is covered by regfile write-through
  //------------------------------------------------------------------------
  assign hit_x = dx.valid && dx.we &&
                 ((use_a && dx.rd == rf_raddr_a) || (use_b && dx.rd == rf_raddr_b));
  assign hit_m = xm.valid && xm.we &&
                 ((use_a && xm.rd == rf_raddr_a) || (use_b && xm.rd == rf_raddr_b));
  assign stall = valid_d && (hit_x || hit_m);

  always_ff @(posedge clk) begin
    dx.alu_op  <= alu_op;
    dx.mem_op  <= mem_op;
    dx.rd      <= rd;
    dx.we      <= writes && (rd != '0);  // x0 writes dropped here, once
    dx.op_a    <= rf_rdata_a;
    dx.op_b    <= op_b;
    dx.st_data <= rf_rdata_b;
    if (reset) dx.valid <= 1'b0;
    else       dx.valid <= valid_d && known && !stall;  // Bubble on stall
  end

endmodule

// File: design/rv_regfile.sv
//--------------------------------------------------------------------------
// 2R1W register file, no reset on contents. x0 reads as zero
// Same-cycle W write is forwarded to both read ports
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_pipe_config.svh"

module rv_regfile import rv_pipe_pkg::*; (
  input  logic     clk,
  input  reg_idx_t raddr_a,
  input  reg_idx_t raddr_b,
  input  wb_t      wr,
  output word_t    rdata_a,
  output word_t    rdata_b
);

  word_t regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (wr.valid) regs[wr.rd] <= wr.data;  // wr.valid never set for x0
  end

  // Same priority on both ports, x0 first, then the W write
  always_comb begin
    if (raddr_a == '0)                     rdata_a = '0;
    else if (wr.valid && wr.rd == raddr_a) rdata_a = wr.data;  // Write-through
    else                                   rdata_a = regs[raddr_a];
    if (raddr_b == '0)                     rdata_b = '0;
    else if (wr.valid && wr.rd == raddr_b) rdata_b = wr.data;
    else                                   rdata_b = regs[raddr_b];
  end

endmodule

// File: design/rv_execute.sv
//--------------------------------------------------------------------------
// Execute. ALU plus data-memory request, issued straight from the X regs
// X never stalls, so the X->M register loads every cycle
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rv_execute import rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  dx_t       dx,
  output dmem_req_t dmem_req,
  output xm_t       xm
);

  word_t      alu_out;
  logic [4:0] sh;                         // Shift distance

  assign sh = dx.op_b[4:0];

  //------------------------------------------------------------------------
  // ALU
  //------------------------------------------------------------------------
  always_comb begin
    case (dx.alu_op)
      alu_add:    alu_out = dx.op_a + dx.op_b;   // Also load/store address
      alu_sub:    alu_out = dx.op_a - dx.op_b;
      alu_sll:    alu_out = dx.op_a << sh;
      alu_slt:    alu_out = word_t'($signed(dx.op_a) < $signed(dx.op_b));
      alu_sltu:   alu_out = word_t'(dx.op_a < dx.op_b);
      alu_xor:    alu_out = dx.op_a ^ dx.op_b;
      alu_srl:    alu_out = dx.op_a >> sh;
      alu_sra:    alu_out = word_t'($signed(dx.op_a) >>> sh);  // Sign fill
      alu_or:     alu_out = dx.op_a | dx.op_b;
      alu_and:    alu_out = dx.op_a & dx.op_b;
      alu_pass_b: alu_out = dx.op_b;              // LUI
      default:    alu_out = dx.op_a + dx.op_b;
    endcase
  end

  // Request lives only in X, response comes back during M
  assign dmem_req.valid = dx.valid && (dx.mem_op != mem_none);
  assign dmem_req.write = (dx.mem_op == mem_sw);
  assign dmem_req.addr  = alu_out;
  assign dmem_req.wdata = dx.st_data;

  //------------------------------------------------------------------------
  // X -> M
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    xm.mem_op <= dx.mem_op;
    xm.rd     <= dx.rd;
    xm.we     <= dx.we;
    xm.result <= alu_out;
    if (reset) xm.valid <= 1'b0;
    else       xm.valid <= dx.valid;
  end

endmodule

// File: design/rv_mem_wb.sv
//--------------------------------------------------------------------------
// Memory and writeback. Sub-word loads take the low byte/half of the word
// returned, no lane shift by address
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rv_mem_wb import rv_pipe_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  xm_t   xm,
  input  word_t dmem_rdata,
  output wb_t   wb
);

  word_t load_data;
  word_t wb_data;
  logic  is_load;

  // Load extension
  always_comb begin
    case (xm.mem_op)
      mem_lb:  load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
      mem_lbu: load_data = {24'b0, dmem_rdata[7:0]};
      mem_lh:  load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
      mem_lhu: load_data = {16'b0, dmem_rdata[15:0]};
      default: load_data = dmem_rdata;    // LW
    endcase
  end

  assign is_load = (xm.mem_op != mem_none) && (xm.mem_op != mem_sw);
  assign wb_data = is_load ? load_data : xm.result;

  //------------------------------------------------------------------------
  // M -> W
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    wb.rd   <= xm.rd;
    wb.data <= wb_data;
    if (reset) wb.valid <= 1'b0;
    else       wb.valid <= xm.valid && xm.we;  // we already false for x0
  end

endmodule

// File: design/rv_pipe_core.sv
//--------------------------------------------------------------------------
// Five-stage RV32I core, ALU ops, LUI, loads and SW only
// Both memories answer in one cycle and never push back
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rv_pipe_core import rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,
  output wb_t       wb              // One pulse per register write
);

  logic     stall;
  logic     valid_d;
  word_t    pc_d, inst_d;
  reg_idx_t rf_raddr_a, rf_raddr_b;
  word_t    rf_rdata_a, rf_rdata_b;
  dx_t      dx;
  xm_t      xm;

  rv_fetch i_fetch (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .pc_d      (pc_d),
    .inst_d    (inst_d),
    .valid_d   (valid_d)
  );

  rv_decode i_decode (
    .clk        (clk),
    .reset      (reset),
    .pc_d       (pc_d),
    .inst_d     (inst_d),
    .valid_d    (valid_d),
    .xm         (xm),           // Hazard source in M
    .rf_rdata_a (rf_rdata_a),
    .rf_rdata_b (rf_rdata_b),
    .stall      (stall),
    .rf_raddr_a (rf_raddr_a),
    .rf_raddr_b (rf_raddr_b),
    .dx         (dx)
  );

  rv_regfile i_regfile (
    .clk     (clk),
    .raddr_a (rf_raddr_a),
    .raddr_b (rf_raddr_b),
    .wr      (wb),              // W stage write port
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b)
  );

  rv_execute i_execute (
    .clk      (clk),
    .reset    (reset),
    .dx       (dx),
    .dmem_req (dmem_req),
    .xm       (xm)
  );

  rv_mem_wb i_mem_wb (
    .clk        (clk),
    .reset      (reset),
    .xm         (xm),
    .dmem_rdata (dmem_rdata),
    .wb         (wb)
  );

endmodule

// File: dv/rv_pipe_core_assertions.sv
//--------------------------------------------------------------------------
// Protocol checks bound into the core. Only SW is word-checked for alignment
// since the request port does not carry the access size
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module rv_pipe_core_assertions import rv_pipe_pkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      stall,
  input word_t     pc_d,
  input word_t     imem_addr,
  input wb_t       wb,
  input dmem_req_t dmem_req
);

  int fail_count = 0;                     // Failed assertions so far

  // First instruction cannot reach W before the fifth edge
  a_quiet_wb: assert property (@(posedge clk) $fell(reset) |-> (!wb.valid) [*4])
    else begin
      $error("Writeback valid too soon after reset");
      fail_count++;
    end

  // A store at the reset vector can reach X on the third edge
  a_quiet_req: assert property (@(posedge clk) $fell(reset) |-> (!dmem_req.valid) [*2])
    else begin
      $error("Data request valid too soon after reset");
      fail_count++;
    end

  a_wb_rd: assert property (@(posedge clk) disable iff (reset) wb.valid |-> wb.rd != '0)
    else begin
      $error("Writeback to x0");
      fail_count++;
    end

  // Replayed fetch keeps the same instruction in D
  a_replay: assert property (@(posedge clk) disable iff (reset) stall |=> $stable(pc_d))
    else begin
      $error("Stall without replay of the D-stage pc");
      fail_count++;
    end

  a_align: assert property (@(posedge clk) disable iff (reset)
    (dmem_req.valid && dmem_req.write) |-> dmem_req.addr[1:0] == 2'b00)
    else begin
      $error("Unaligned word store");
      fail_count++;
    end

endmodule

bind rv_pipe_core rv_pipe_core_assertions i_assertions (
  .clk       (clk),
  .reset     (reset),
  .stall     (stall),
  .pc_d      (pc_d),
  .imem_addr (imem_addr),
  .wb        (wb),
  .dmem_req  (dmem_req)
);

// File: dv/rv_pipe_core_tb.sv
//--------------------------------------------------------------------------
// Directed tests with an ISA reference model. Data memory is 256 words at 0
// Loads use word-aligned addresses only, the core takes the low lanes
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_pipe_config.svh"

module rv_pipe_core_tb import rv_pipe_pkg::*;;

  localparam logic [6:0] OPC_OP = 7'b0110011, OPC_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111, OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam word_t      NOP = 32'h0000_0013;       // addi x0,x0,0

  logic clk, reset;
  word_t imem_addr, imem_data, dmem_rdata, fetch_addr;
  dmem_req_t dmem_req, req_q;
  wb_t wb, exp_w;
  word_t imem [256], dmem [256], mmem [256], mregs [32];
  word_t prog [$];
  wb_t exp_wb [$];
  logic [63:0] exp_st [$], st;                       // {addr, data}
  logic [15:0] lfsr_state = 16'd73;
  int errors = 0, checks = 0;
  string test_name = "init";

  rv_pipe_core i_dut (.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .wb(wb));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                           // 8 ns period
  end

  //------------------------------------------------------------------------
  // Memory models, one-cycle latency
  //------------------------------------------------------------------------
  function automatic word_t fill(input int i);
    return ({i[29:0], 2'b00} * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
  endfunction

  function automatic word_t imem_word(input word_t a);
    if ($isunknown(a) || a < `RV_RESET_VECTOR || a >= `RV_RESET_VECTOR + 1024) return NOP;
    return imem[(a - `RV_RESET_VECTOR) >> 2];
  endfunction

  always @(posedge clk) begin
    fetch_addr <= imem_addr;
    req_q      <= dmem_req;
    if (dmem_req.valid === 1'b1 && dmem_req.write === 1'b1)
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;    // Store lands at the edge
  end

  always @(negedge clk) begin
    imem_data  <= imem_word(fetch_addr);
    dmem_rdata <= $isunknown(req_q.addr) ? '0 : dmem[req_q.addr[9:2]];
  end

  //------------------------------------------------------------------------
  // Checking
  //------------------------------------------------------------------------
  task automatic check(input string what, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  always @(negedge clk) begin
    if (reset === 1'b0 && wb.valid === 1'b1) begin
      if (exp_wb.size() == 0) begin
        errors++;
        $display("%s: writeback to x%0d that the program should not make", test_name, wb.rd);
      end else begin
        exp_w = exp_wb.pop_front();
        check("wb rd", word_t'(exp_w.rd), word_t'(wb.rd));
        check("wb data", exp_w.data, wb.data);
      end
    end
    if (reset === 1'b0 && dmem_req.valid === 1'b1 && dmem_req.write === 1'b1) begin
      if (exp_st.size() == 0) begin
        errors++;
        $display("%s: store to %h that the program should not make", test_name, dmem_req.addr);
      end else begin
        st = exp_st.pop_front();
        check("store addr", st[63:32], dmem_req.addr);
        check("store data", st[31:0], dmem_req.wdata);
      end
    end
  end

  //------------------------------------------------------------------------
  // Reference ISA model
  //------------------------------------------------------------------------
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a, b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_step(input word_t inst);
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    word_t a, b, imm, res, addr, w;
    logic wr;
    rd  = inst[11:7];
    rs1 = inst[19:15];
    rs2 = inst[24:20];
    f3  = inst[14:12];
    a = mregs[rs1];
    b = mregs[rs2];
    imm = {{20{inst[31]}}, inst[31:20]};
    wr = 1'b1;
    res = '0;
    case (inst[6:0])
      OPC_OP:  res = alu_ref(f3, inst[30], a, b);
      OPC_IMM: res = alu_ref(f3, f3 == 3'd5 && inst[30], a,
                             (f3[1:0] == 2'b01) ? {27'd0, rs2} : imm);
      OPC_LUI: res = {inst[31:12], 12'd0};
      OPC_LOAD: begin
        w = mmem[(a + imm) >> 2 & 32'hFF];
        case (f3)
          3'd0: res = {{24{w[7]}}, w[7:0]};
          3'd1: res = {{16{w[15]}}, w[15:0]};
          3'd4: res = {24'd0, w[7:0]};
          3'd5: res = {16'd0, w[15:0]};
          default: res = w;
        endcase
      end
      default: begin                                 // SW only
        wr = 1'b0;
        addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        mmem[addr >> 2 & 32'hFF] = b;
        exp_st.push_back({addr, b});
      end
    endcase
    if (wr && rd != 0) begin
      mregs[rd] = res;
      exp_wb.push_back('{valid: 1'b1, rd: rd, data: res});
    end
  endtask

  //------------------------------------------------------------------------
  // Stimulus helpers
  //------------------------------------------------------------------------
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};  // One step per bit
    return v;
  endfunction

  function automatic word_t r_op(input logic [6:0] f7, input logic [2:0] f3,
                                 input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_op(input logic [6:0] opc, input logic [2:0] f3,
                                 input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t sw_op(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  task automatic load_const(input logic [4:0] rd, input word_t v);
    word_t hi;
    hi = v + 32'h800;                                // Undo the ADDI sign extension
    prog.push_back({hi[31:12], rd, OPC_LUI});
    prog.push_back(i_op(OPC_IMM, 3'd0, rd, rd, v[11:0]));
  endtask

  task automatic start_program(input string name);
    test_name = name;
    prog.delete();
    foreach (mregs[i]) mregs[i] = '0;
  endtask

  // Runs prog from the reset vector and waits for every expected event
  task automatic run_program();
    int limit, cycles;
    @(negedge clk);
    reset = 1'b1;
    foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : NOP;
    foreach (prog[i]) model_step(prog[i]);
    repeat (2) @(negedge clk);
    reset = 1'b0;
    limit = 20 * prog.size() + 50;
    cycles = 0;
    while (exp_wb.size() != 0 || exp_st.size() != 0) begin
      @(negedge clk);
      if (++cycles > limit) begin
        $display("Timeout in %s: %0d writebacks and %0d stores never arrived",
                 test_name, exp_wb.size(), exp_st.size());
        $display("TEST FAILED");
        $finish;
      end
    end
    repeat (12) @(negedge clk);                      // Catch stray writebacks
  endtask

  //------------------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------------------
  task automatic fetch_after_reset();
    start_program("reset_fetch");
    @(negedge clk);
    reset = 1'b1;
    foreach (imem[i]) imem[i] = NOP;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < 8; i++) begin
      check("imem_addr", `RV_RESET_VECTOR + 4 * i, imem_addr);
      @(negedge clk);
    end
  endtask

  task automatic reg_reg_alu_ops();
    start_program("alu_rr");
    load_const(5'd1, rand_bits(32));
    load_const(5'd2, rand_bits(32));
    for (int f = 0; f < 8; f++) prog.push_back(r_op(7'h00, f[2:0], 5'(f + 3), 5'd1, 5'd2));
    prog.push_back(r_op(7'h20, 3'd0, 5'd11, 5'd1, 5'd2));  // SUB
    prog.push_back(r_op(7'h20, 3'd5, 5'd12, 5'd2, 5'd1));  // SRA
    run_program();
  endtask

  task automatic imm_alu_ops();
    start_program("alu_imm");
    load_const(5'd1, rand_bits(32));
    for (int f = 0; f < 8; f++)
      if (f != 1 && f != 5)
        prog.push_back(i_op(OPC_IMM, f[2:0], 5'(f + 2), 5'd1, 12'(rand_bits(12))));
    prog.push_back(i_op(OPC_IMM, 3'd1, 5'd10, 5'd1, {7'h00, 5'(rand_bits(5))}));  // SLLI
    prog.push_back(i_op(OPC_IMM, 3'd5, 5'd11, 5'd1, {7'h00, 5'(rand_bits(5))}));  // SRLI
    prog.push_back(i_op(OPC_IMM, 3'd5, 5'd12, 5'd1, {7'h20, 5'(rand_bits(5))}));  // SRAI
    prog.push_back({20'(rand_bits(20)), 5'd13, OPC_LUI});
    run_program();
  endtask

  task automatic dependent_chains();
    start_program("dependent");
    load_const(5'd1, rand_bits(32));
    prog.push_back(i_op(OPC_IMM, 3'd0, 5'd1, 5'd1, 12'd1));
    prog.push_back(r_op(7'h00, 3'd0, 5'd2, 5'd1, 5'd1));
    prog.push_back(r_op(7'h20, 3'd0, 5'd3, 5'd2, 5'd1));
    prog.push_back(r_op(7'h00, 3'd4, 5'd3, 5'd3, 5'd2));
    prog.push_back(i_op(OPC_IMM, 3'd1, 5'd4, 5'd3, 12'd3));
    prog.push_back(r_op(7'h00, 3'd0, 5'd4, 5'd4, 5'd4));
    prog.push_back(r_op(7'h00, 3'd6, 5'd5, 5'd4, 5'd3));
    run_program();
  endtask

  task automatic store_then_loads();
    start_program("load_store");
    load_const(5'd2, rand_bits(32));
    load_const(5'd9, 32'h8000_8080 | rand_bits(32) & 32'h0F0F_0F0F);  // Sign bits set
    prog.push_back(i_op(OPC_IMM, 3'd0, 5'd3, 5'd0, 12'h100));         // Base address
    prog.push_back(sw_op(5'd2, 5'd3, 12'd8));
    prog.push_back(sw_op(5'd9, 5'd3, 12'd12));
    for (int k = 0; k < 2; k++) begin
      prog.push_back(i_op(OPC_LOAD, 3'd2, 5'(4 + 5 * k), 5'd3, 12'(8 + 4 * k)));
      prog.push_back(i_op(OPC_LOAD, 3'd0, 5'(5 + 5 * k), 5'd3, 12'(8 + 4 * k)));
      prog.push_back(i_op(OPC_LOAD, 3'd4, 5'(6 + 5 * k), 5'd3, 12'(8 + 4 * k)));
      prog.push_back(i_op(OPC_LOAD, 3'd1, 5'(7 + 5 * k), 5'd3, 12'(8 + 4 * k)));
      prog.push_back(i_op(OPC_LOAD, 3'd5, 5'(8 + 5 * k), 5'd3, 12'(8 + 4 * k)));
    end
    prog.push_back(r_op(7'h00, 3'd0, 5'd20, 5'd13, 5'd12));  // Use a load result at once
    run_program();
  endtask

  task automatic x0_writes();
    start_program("x0");
    load_const(5'd1, rand_bits(32));
    prog.push_back(i_op(OPC_IMM, 3'd0, 5'd0, 5'd0, 12'd5));
    prog.push_back({20'(rand_bits(20)), 5'd0, OPC_LUI});
    prog.push_back(r_op(7'h00, 3'd0, 5'd0, 5'd1, 5'd1));
    prog.push_back(i_op(OPC_LOAD, 3'd2, 5'd0, 5'd0, 12'h108));
    prog.push_back(r_op(7'h00, 3'd0, 5'd2, 5'd0, 5'd1));
    prog.push_back(r_op(7'h00, 3'd6, 5'd3, 5'd0, 5'd0));
    run_program();
  endtask

  initial begin
    reset = 1'b1;
    imem_data = NOP;
    dmem_rdata = '0;
    foreach (dmem[i]) dmem[i] = fill(i);
    foreach (mmem[i]) mmem[i] = fill(i);
    repeat (2) @(negedge clk);
    fetch_after_reset();
    reg_reg_alu_ops();
    imm_alu_ops();
    dependent_chains();
    store_then_loads();
    x0_writes();
    errors += i_dut.i_assertions.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: rv_pipe_core.f
+incdir+design
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_mem_wb.sv
design/rv_pipe_core.sv
dv/rv_pipe_core_assertions.sv
dv/rv_pipe_core_tb.sv
